//--- design/cx4_map_pkg.sv
package cx4_map_pkg;

  //////////////////////////////////////////////////
  // host side data and address types
  //////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;       // host and bus data
  typedef logic [12:0] host_addr_t;  // host window offset
  typedef logic [11:0] ram_addr_t;   // data RAM index

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  localparam logic [11:0] RAM_WINDOW_END = 12'hC00;  // ram below 0xc00
  localparam logic [7:0]  MMIO_PAGE      = 8'hFA;    // addr[12:5] of 0x1f40 page
  localparam logic [4:0]  MMIO_REG_COUNT = 5'd8;     // 0x1f40..0x1f47
  localparam logic [4:0]  STATUS_FIRST   = 5'h13;    // 0x1f53 onward

  // status byte layout
  localparam logic [2:0] STATUS_BUSY_BIT = 3'd6;
  localparam logic [2:0] STATUS_IDLE_BIT = 3'd1;

  // nwr must be seen low this many samples minus one before the rise
  localparam logic [2:0] WR_HISTORY = 3'd6;

endpackage

//--- design/cx4_dma_pkg.sv
package cx4_dma_pkg;

  //////////////////////////////////////////////////
  // DMA address and count types
  //////////////////////////////////////////////////

  typedef logic [23:0] src_addr_t;  // full cartridge address
  typedef logic [22:0] bus_addr_t;  // bank + 15-bit offset
  typedef logic [15:0] dma_len_t;   // zero means 65536

  localparam logic [4:0] BANK_LSB = 5'd16;  // bank field start

  //////////////////////////////////////////////////
  // engine states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    dma_idle,
    dma_start,
    dma_wait,
    dma_addr
  } dma_state_t;

endpackage

//--- design/host_port.sv
`timescale 1ns/10ps

module host_port (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  cx4_map_pkg::host_addr_t addr,
  input  cx4_map_pkg::byte_t      di,
  input  logic                    cs,
  input  logic                    nwr,
  input  logic                    busy,
  input  cx4_map_pkg::byte_t      ram_rdata,
  input  cx4_map_pkg::byte_t      reg_rdata,
  output cx4_map_pkg::byte_t      wr_data,
  output logic                    ram_we,
  output logic                    reg_we,
  output logic [2:0]              reg_sel,
  output cx4_map_pkg::byte_t      rd_data
);

  logic [cx4_map_pkg::WR_HISTORY-1:0] nwr_hist;
  logic                               wr_en;
  logic                               page_hit;
  logic                               ram_hit;
  logic                               reg_hit;
  logic                               status_hit;
  cx4_map_pkg::byte_t                 status;

  //////////////////////////////////////////////////
  // write strobe
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      nwr_hist <= '1;  // idle high
      wr_data  <= '0;
    end else begin
      nwr_hist <= {nwr_hist[cx4_map_pkg::WR_HISTORY-2:0], nwr};
      wr_data  <= di;
    end
  end

  // five lows then the rising sample
  assign wr_en = (nwr_hist == {{(cx4_map_pkg::WR_HISTORY - 1){1'b0}}, 1'b1});

  //////////////////////////////////////////////////
  // window decode
  //////////////////////////////////////////////////

  assign page_hit   = cs && (addr[12:5] == cx4_map_pkg::MMIO_PAGE);
  assign ram_hit    = cs && (addr[11:0] < cx4_map_pkg::RAM_WINDOW_END);
  assign reg_hit    = page_hit && (addr[4:0] < cx4_map_pkg::MMIO_REG_COUNT);
  assign status_hit = page_hit && (addr[4:0] >= cx4_map_pkg::STATUS_FIRST);

  assign ram_we  = wr_en && ram_hit;
  assign reg_we  = wr_en && reg_hit;
  assign reg_sel = addr[2:0];

  always_comb begin
    status = '0;
    status[cx4_map_pkg::STATUS_BUSY_BIT] = busy;
    status[cx4_map_pkg::STATUS_IDLE_BIT] = !busy;
  end

  always_comb begin
    if (ram_hit) begin
      rd_data = ram_rdata;
    end else if (reg_hit) begin
      rd_data = reg_rdata;
    end else if (status_hit) begin
      rd_data = status;  // live status without pipeline
    end else begin
      rd_data = '0;
    end
  end

endmodule

//--- design/dma_regs.sv
`timescale 1ns/10ps

module dma_regs (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   reg_we,
  input  logic [2:0]             reg_sel,
  input  cx4_map_pkg::byte_t     wr_data,
  output cx4_map_pkg::byte_t     reg_rdata,
  output cx4_dma_pkg::src_addr_t src,
  output cx4_dma_pkg::dma_len_t  len,
  output cx4_map_pkg::ram_addr_t tgt,
  output logic                   start
);

  logic [23:0] tgt_full;  // upper bits kept for readback only

  //////////////////////////////////////////////////
  // host writes, little endian bytes
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      src      <= '0;
      len      <= '0;
      tgt_full <= '0;
      start    <= 1'b0;
    end else begin
      start <= reg_we && (reg_sel == 3'd7);  // 0x1f47 kicks the engine
      if (reg_we) begin
        case (reg_sel)
          3'd0: src[7:0]        <= wr_data;
          3'd1: src[15:8]       <= wr_data;
          3'd2: src[23:16]      <= wr_data;
          3'd3: len[7:0]        <= wr_data;
          3'd4: len[15:8]       <= wr_data;
          3'd5: tgt_full[7:0]   <= wr_data;
          3'd6: tgt_full[15:8]  <= wr_data;
          3'd7: tgt_full[23:16] <= wr_data;
          default: ;
        endcase
      end
    end
  end

  assign tgt = tgt_full[11:0];  // ram index wraps at 4k

  //////////////////////////////////////////////////
  // readback, one cycle behind reg_sel
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else begin
      case (reg_sel)
        3'd0: reg_rdata <= src[7:0];
        3'd1: reg_rdata <= src[15:8];
        3'd2: reg_rdata <= src[23:16];
        3'd3: reg_rdata <= len[7:0];
        3'd4: reg_rdata <= len[15:8];
        3'd5: reg_rdata <= tgt_full[7:0];
        3'd6: reg_rdata <= tgt_full[15:8];
        default: reg_rdata <= tgt_full[23:16];
      endcase
    end
  end

endmodule

//--- design/dma_ctrl.sv
`timescale 1ns/10ps

module dma_ctrl (
  input  logic CLK,
  input  logic rst_n,
  input  logic start,
  input  logic bus_rdy,
  input  logic count_zero,
  output logic busy,
  output logic bus_rrq,
  output logic load,
  output logic take,
  output logic advance,
  output logic dma_we
);

  cx4_dma_pkg::dma_state_t state;

  //////////////////////////////////////////////////
  // per byte: request, ready, write + advance
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state   <= cx4_dma_pkg::dma_idle;
      busy    <= 1'b0;
      bus_rrq <= 1'b0;
    end else begin
      case (state)
        cx4_dma_pkg::dma_idle: begin
          if (start) begin
            state <= cx4_dma_pkg::dma_start;
          end
        end
        cx4_dma_pkg::dma_start: begin
          busy    <= 1'b1;
          bus_rrq <= 1'b1;  // first request with the loaded address
          state   <= cx4_dma_pkg::dma_wait;
        end
        cx4_dma_pkg::dma_wait: begin
          bus_rrq <= 1'b0;
          if (take) begin
            state <= cx4_dma_pkg::dma_addr;
          end
        end
        cx4_dma_pkg::dma_addr: begin
          if (count_zero) begin
            busy  <= 1'b0;
            state <= cx4_dma_pkg::dma_idle;
          end else begin
            bus_rrq <= 1'b1;
            state   <= cx4_dma_pkg::dma_wait;
          end
        end
        default: begin
          state <= cx4_dma_pkg::dma_idle;
        end
      endcase
    end
  end

  assign load = (state == cx4_dma_pkg::dma_start);

  // ready is ignored in the request cycle itself
  assign take = (state == cx4_dma_pkg::dma_wait) && !bus_rrq && bus_rdy;

  assign advance = (state == cx4_dma_pkg::dma_addr);
  assign dma_we  = (state == cx4_dma_pkg::dma_addr);  // bus_di still held by the bus

endmodule

//--- design/dma_addr_gen.sv
`timescale 1ns/10ps

module dma_addr_gen (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic                   take,
  input  logic                   advance,
  input  cx4_dma_pkg::src_addr_t src,
  input  cx4_dma_pkg::dma_len_t  len,
  input  cx4_map_pkg::ram_addr_t tgt,
  output cx4_dma_pkg::bus_addr_t bus_addr,
  output cx4_map_pkg::ram_addr_t ram_addr,
  output logic                   count_zero
);

  cx4_dma_pkg::src_addr_t src_cnt;
  cx4_dma_pkg::dma_len_t  remain;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      src_cnt  <= '0;
      ram_addr <= '0;
      remain   <= '0;
    end else if (load) begin
      src_cnt  <= src;
      ram_addr <= tgt;
      remain   <= len;
    end else if (take) begin
      remain <= remain - 1'b1;  // zero wraps to 65535
    end else if (advance) begin
      src_cnt  <= src_cnt + 1'b1;
      ram_addr <= ram_addr + 1'b1;
    end
  end

  assign count_zero = (remain == '0);

  // drop bit 15, bank follows offset directly
  assign bus_addr = {src_cnt[23:cx4_dma_pkg::BANK_LSB],
                     src_cnt[cx4_dma_pkg::BANK_LSB-2:0]};

endmodule

//--- design/data_ram.sv
`timescale 1ns/10ps

module data_ram (
  input  logic                   CLK,
  input  cx4_map_pkg::ram_addr_t host_addr,
  input  logic                   host_we,
  input  cx4_map_pkg::byte_t     host_wdata,
  output cx4_map_pkg::byte_t     host_rdata,
  input  cx4_map_pkg::ram_addr_t dma_addr,
  input  logic                   dma_we,
  input  cx4_map_pkg::byte_t     dma_wdata
);

  cx4_map_pkg::byte_t mem [0:4095];

  // host port: write plus registered read
  // dma port: write only
  always_ff @(posedge CLK) begin
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    if (dma_we) begin
      mem[dma_addr] <= dma_wdata;  // engine wins a same-address clash
    end
    host_rdata <= mem[host_addr];
  end

endmodule

//--- design/cx4_dma.sv
`timescale 1ns/10ps

module cx4_dma (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  cx4_map_pkg::host_addr_t addr,
  input  cx4_map_pkg::byte_t      di,
  input  logic                    cs,
  input  logic                    nwr,
  output cx4_map_pkg::byte_t      rd_data,
  input  cx4_map_pkg::byte_t      bus_di,
  input  logic                    bus_rdy,
  output cx4_dma_pkg::bus_addr_t  bus_addr,
  output logic                    bus_rrq,
  output logic                    cx4_active
);

  cx4_map_pkg::byte_t     wr_data;
  cx4_map_pkg::byte_t     ram_rdata;
  cx4_map_pkg::byte_t     reg_rdata;
  logic                   ram_we;
  logic                   reg_we;
  logic [2:0]             reg_sel;
  cx4_dma_pkg::src_addr_t src;
  cx4_dma_pkg::dma_len_t  len;
  cx4_map_pkg::ram_addr_t tgt;
  cx4_map_pkg::ram_addr_t ram_addr;
  logic                   start;
  logic                   load;
  logic                   take;
  logic                   advance;
  logic                   dma_we;
  logic                   count_zero;

  //////////////////////////////////////////////////
  // host side
  //////////////////////////////////////////////////

  host_port host_port_i (
    .CLK(CLK), .rst_n(rst_n),
    .addr(addr), .di(di), .cs(cs), .nwr(nwr), .busy(cx4_active),
    .ram_rdata(ram_rdata), .reg_rdata(reg_rdata),
    .wr_data(wr_data), .ram_we(ram_we), .reg_we(reg_we),
    .reg_sel(reg_sel), .rd_data(rd_data)
  );

  dma_regs dma_regs_i (
    .CLK(CLK), .rst_n(rst_n),
    .reg_we(reg_we), .reg_sel(reg_sel), .wr_data(wr_data),
    .reg_rdata(reg_rdata), .src(src), .len(len), .tgt(tgt), .start(start)
  );

  //////////////////////////////////////////////////
  // engine
  //////////////////////////////////////////////////

  dma_ctrl dma_ctrl_i (
    .CLK(CLK), .rst_n(rst_n),
    .start(start), .bus_rdy(bus_rdy), .count_zero(count_zero),
    .busy(cx4_active), .bus_rrq(bus_rrq),  // active is the dma busy flag
    .load(load), .take(take), .advance(advance), .dma_we(dma_we)
  );

  dma_addr_gen dma_addr_gen_i (
    .CLK(CLK), .rst_n(rst_n),
    .load(load), .take(take), .advance(advance),
    .src(src), .len(len), .tgt(tgt),
    .bus_addr(bus_addr), .ram_addr(ram_addr), .count_zero(count_zero)
  );

  data_ram data_ram_i (
    .CLK(CLK),
    .host_addr(addr[11:0]), .host_we(ram_we), .host_wdata(wr_data),
    .host_rdata(ram_rdata),
    .dma_addr(ram_addr), .dma_we(dma_we), .dma_wdata(bus_di)
  );

endmodule

//--- verif/tb_cx4_dma.sv
`timescale 1ns/10ps

module tb_cx4_dma;

  localparam int unsigned MAX_CYCLES = 20000;  // whole run needs about 1k

  logic                    CLK;
  logic                    rst_n;
  cx4_map_pkg::host_addr_t addr;
  cx4_map_pkg::byte_t      di;
  logic                    cs;
  logic                    nwr;
  cx4_map_pkg::byte_t      rd_data;
  cx4_map_pkg::byte_t      bus_di;
  logic                    bus_rdy;
  cx4_dma_pkg::bus_addr_t  bus_addr;
  logic                    bus_rrq;
  logic                    cx4_active;

  logic [15:0]             lfsr_state;
  cx4_dma_pkg::src_addr_t  exp_src;  // next source byte the engine should fetch
  int unsigned             req_count;
  int unsigned             cycles;
  cx4_dma_pkg::bus_addr_t  addr_log[$];

  cx4_dma cx4_dma_i (
    .CLK(CLK), .rst_n(rst_n),
    .addr(addr), .di(di), .cs(cs), .nwr(nwr), .rd_data(rd_data),
    .bus_di(bus_di), .bus_rdy(bus_rdy),
    .bus_addr(bus_addr), .bus_rrq(bus_rrq), .cx4_active(cx4_active)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // reference model and error reporting
  //////////////////////////////////////////////////

  function automatic cx4_dma_pkg::bus_addr_t expected_bus_addr(
    input cx4_dma_pkg::src_addr_t s
  );
    return {s[23:16], s[14:0]};  // bit 15 dropped
  endfunction

  function automatic cx4_map_pkg::byte_t model_byte(input cx4_dma_pkg::bus_addr_t a);
    return a[7:0] ^ a[22:15];
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, exp, got);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("t=%0t %s", $time, what);
    stop_with_failure();
  endtask

  // one pulse per request and never outside a transfer
  assert property (@(posedge CLK) disable iff (!rst_n) bus_rrq |=> !bus_rrq)
    else report_failure("bus_rrq stayed high for more than one cycle");
  assert property (@(posedge CLK) disable iff (!rst_n) bus_rrq |-> cx4_active)
    else report_failure("bus_rrq was raised while cx4_active was low");

  //////////////////////////////////////////////////
  // cartridge bus responder
  //////////////////////////////////////////////////

  task automatic draw_delay(output int n);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++) begin
      bits[i]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    n = 1 + int'(bits);
  endtask

  always begin : bus_responder
    int                     delay;
    cx4_dma_pkg::bus_addr_t req_addr;
    @(negedge CLK);
    if (rst_n && bus_rrq) begin
      req_addr = bus_addr;
      assert (req_addr === expected_bus_addr(exp_src))
        else report_mismatch("bus_addr", 32'(expected_bus_addr(exp_src)), 32'(req_addr));
      addr_log.push_back(req_addr);
      exp_src   = exp_src + 24'd1;
      req_count = req_count + 1;
      bus_rdy   = 1'b0;
      draw_delay(delay);
      for (int k = 0; k < delay; k++) begin
        @(negedge CLK);
        assert (!bus_rrq)
          else report_failure("bus_rrq issued again while bus_rdy was still low");
      end
      bus_di  = model_byte(req_addr);
      bus_rdy = 1'b1;  // held until the next request
    end
  end

  //////////////////////////////////////////////////
  // host accesses
  //////////////////////////////////////////////////

  task automatic host_write(input cx4_map_pkg::host_addr_t a, input cx4_map_pkg::byte_t d);
    cs   = 1'b1;
    addr = a;
    di   = d;
    nwr  = 1'b0;
    repeat (6) @(negedge CLK);
    nwr = 1'b1;
    repeat (3) @(negedge CLK);
    cs = 1'b0;
  endtask

  task automatic host_read(input cx4_map_pkg::host_addr_t a, output cx4_map_pkg::byte_t d);
    cs   = 1'b1;
    addr = a;
    repeat (3) @(negedge CLK);
    d  = rd_data;
    cs = 1'b0;
  endtask

  task automatic read_expect(input cx4_map_pkg::host_addr_t a, input cx4_map_pkg::byte_t exp);
    cx4_map_pkg::byte_t got;
    host_read(a, got);
    assert (got === exp)
      else report_mismatch($sformatf("rd_data@%h", a), 32'(exp), 32'(got));
  endtask

  task automatic run_dma(input cx4_dma_pkg::src_addr_t s, input cx4_dma_pkg::dma_len_t n,
                         input logic [23:0] t);
    logic [63:0]            image;
    cx4_dma_pkg::src_addr_t a;
    cx4_map_pkg::ram_addr_t r;
    image     = {t, n, s};
    exp_src   = s;
    req_count = 0;
    addr_log.delete();
    for (int j = 0; j < 8; j++) begin
      host_write(cx4_map_pkg::host_addr_t'(13'h1F40 + j), image[8*j +: 8]);  // 0x1f47 last
    end
    while (!cx4_active) @(negedge CLK);
    read_expect(13'h1F53, 8'h40);
    while (cx4_active) @(negedge CLK);
    assert (req_count == 32'(n))
      else report_mismatch("bus_rrq pulses", 32'(n), 32'(req_count));
    read_expect(13'h1F53, 8'h02);
    for (int i = 0; i < int'(n); i++) begin
      a = s + 24'(i);
      r = t[11:0] + 12'(i);  // target wraps at 4k
      read_expect({1'b0, r}, model_byte(expected_bus_addr(a)));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and timeout
  //////////////////////////////////////////////////

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles = cycles + 1;
    end
    $display("timeout after %0d cycles, a transfer or host access never finished", cycles);
    stop_with_failure();
  end

  initial begin : stimulus
    rst_n       = 1'b0;
    addr        = '0;
    di          = '0;
    cs          = 1'b0;
    nwr         = 1'b1;
    bus_di      = '0;
    bus_rdy     = 1'b1;
    lfsr_state  = 16'd73;
    exp_src     = '0;
    req_count   = 0;
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);

    assert (cx4_active === 1'b0) else report_mismatch("cx4_active", 32'd0, 32'(cx4_active));
    assert (bus_rrq === 1'b0) else report_mismatch("bus_rrq", 32'd0, 32'(bus_rrq));
    read_expect(13'h1F53, 8'h02);
    read_expect(13'h1F5F, 8'h02);

    // register readback with 0x1f47 left alone so nothing starts
    for (int i = 0; i < 7; i++) begin
      host_write(cx4_map_pkg::host_addr_t'(13'h1F40 + i), 8'(8'h11 * (i + 1)));
    end
    for (int i = 0; i < 7; i++) begin
      read_expect(cx4_map_pkg::host_addr_t'(13'h1F40 + i), 8'(8'h11 * (i + 1)));
    end
    read_expect(13'h1F48, 8'h00);

    host_write(13'h000, 8'hA5);
    host_write(13'hBFF, 8'h5A);
    read_expect(13'h000, 8'hA5);
    read_expect(13'hBFF, 8'h5A);

    run_dma(24'h05_1234, 16'd20, 24'h00_0100);

    // bank 0x12 crossing its 32k half
    run_dma(24'h12_7FFE, 16'd4, 24'h00_0300);
    assert (addr_log[1] === {8'h12, 15'h7FFF})
      else report_mismatch("bus_addr", 32'({8'h12, 15'h7FFF}), 32'(addr_log[1]));
    assert (addr_log[2] === {8'h12, 15'h0000})
      else report_mismatch("bus_addr", 32'({8'h12, 15'h0000}), 32'(addr_log[2]));

    run_dma(24'h3C_FFF8, 16'd16, 24'hAB_15F0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- list.f
design/cx4_map_pkg.sv
design/cx4_dma_pkg.sv
design/host_port.sv
design/dma_regs.sv
design/dma_ctrl.sv
design/dma_addr_gen.sv
design/data_ram.sv
design/cx4_dma.sv
verif/tb_cx4_dma.sv

//--- Bender.yml
package:
  name: cx4_dma

sources:
  # packages first, then leaf modules, then the top level
  - design/cx4_map_pkg.sv
  - design/cx4_dma_pkg.sv
  - design/host_port.sv
  - design/dma_regs.sv
  - design/dma_ctrl.sv
  - design/dma_addr_gen.sv
  - design/data_ram.sv
  - design/cx4_dma.sv

  - target: test
    files:
      - verif/tb_cx4_dma.sv
